/* files.f */
axi_pkg.sv
dma_pkg.sv
dma_rd_cmd_decode.sv
dma_rd_ar_issue.sv
dma_rd_burst_fifo.sv
dma_rd_r_stream.sv
dma_rd_top.sv
tb_axi_rd_slave.sv
tb_dma_rd.sv

/* Makefile */
# Verilator build and run of the AXI4 read DMA testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_dma_rd: files.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module tb_dma_rd -f files.f -o Vtb_dma_rd

# Pass only when the log holds the pass line
run: obj_dir/Vtb_dma_rd
	./obj_dir/Vtb_dma_rd | tee sim.log
	grep -q "^TEST OK$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module dma_rd_top -f files.f

clean:
	rm -rf obj_dir sim.log

/* tb_dma_rd.sv */
// DMA read testbench; in-order slave model, fixed seed, stops at the first error
`timescale 1ns/1ns
`default_nettype none

module tb_dma_rd;

  localparam logic [31:0] SEED = 32'hd276_52e0;
  localparam int N_CMD = 8;
  localparam int MAX_BURSTS = 4;

  //////////////////////////////////////////////////////////////////////
  // Command table
  //////////////////////////////////////////////////////////////////////

  // Single beat, full burst, partial, 8 bursts, 25 beats, page cross, 17 beats, 8 beats
  localparam logic [31:0] TBL_ADDR [N_CMD] = '{
    32'h0000_1000, 32'h0000_2000, 32'h0000_3000, 32'h0001_0000,
    32'h0000_4080, 32'h0002_0f00, 32'h0000_5000, 32'h0000_6000
  };
  localparam logic [19:0] TBL_LEN [N_CMD] = '{
    20'd8, 20'd128, 20'd40, 20'd1024, 20'd200, 20'd512, 20'd136, 20'd64
  };
  localparam logic TBL_CTL [N_CMD] = '{
    1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1
  };

  logic        aclk = 1'b0;
  logic        aresetn;
  logic        ctrl_valid;
  logic [31:0] ctrl_addr;
  logic [19:0] ctrl_len;
  logic        ctrl_ctl;
  logic        stat_ready;
  logic        stat_done;
  logic        arvalid;
  logic        arready;
  logic [31:0] araddr;
  logic [1:0]  arid;
  logic [7:0]  arlen;
  logic [2:0]  arsize;
  logic [1:0]  arburst;
  logic [0:0]  arlock;
  logic [3:0]  arcache;
  logic [2:0]  arprot;
  logic        rvalid;
  logic        rready;
  logic [63:0] rdata;
  logic        rlast;
  logic [1:0]  rid;
  logic [1:0]  rresp;
  logic        axis_out_tvalid;
  logic        axis_out_tready;
  logic [63:0] axis_out_tdata;
  logic [7:0]  axis_out_tkeep;
  logic        axis_out_tlast;

  // Checker progress
  int ar_cmd = 0;
  int ar_idx = 0;
  int s_cmd = 0;
  int s_beat = 0;
  int outstanding = 0;
  int acc_count = 0;
  int cycles = 0;
  int cycle_limit = 1000;
  logic overlap_seen = 1'b0;

  always #5 aclk = ~aclk;

  dma_rd_top i_dut (
    .aclk (aclk), .aresetn (aresetn),
    .ctrl_valid (ctrl_valid), .stat_ready (stat_ready), .ctrl_addr (ctrl_addr),
    .ctrl_len (ctrl_len), .ctrl_ctl (ctrl_ctl), .stat_done (stat_done),
    .arvalid (arvalid), .arready (arready), .araddr (araddr), .arid (arid),
    .arlen (arlen), .arsize (arsize), .arburst (arburst), .arlock (arlock),
    .arcache (arcache), .arprot (arprot),
    .rvalid (rvalid), .rready (rready), .rdata (rdata), .rlast (rlast),
    .rid (rid), .rresp (rresp),
    .axis_out_tvalid (axis_out_tvalid), .axis_out_tready (axis_out_tready),
    .axis_out_tdata (axis_out_tdata), .axis_out_tkeep (axis_out_tkeep),
    .axis_out_tlast (axis_out_tlast)
  );

  tb_axi_rd_slave i_mem (
    .aclk (aclk), .aresetn (aresetn),
    .arvalid (arvalid), .arready (arready), .araddr (araddr), .arlen (arlen),
    .rvalid (rvalid), .rready (rready), .rdata (rdata), .rlast (rlast),
    .rid (rid), .rresp (rresp)
  );

  function automatic int beats_of(input int k);
    return int'(TBL_LEN[k]) / 8;
  endfunction

  function automatic int bursts_of(input int k);
    return (beats_of(k) + 15) / 16;
  endfunction

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  //////////////////////////////////////////////////////////////////////
  // AR and stream checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_ar();
    logic [31:0] exp_addr;
    logic [7:0]  exp_len;
    assert (ar_cmd < N_CMD) else stop_run("AR handshake after the whole table was issued");
    if (ar_cmd < N_CMD) begin
      exp_addr = TBL_ADDR[ar_cmd] + 32'(ar_idx * 128);
      // Full bursts are 16 beats, the last one holds the rest
      exp_len = (ar_idx == bursts_of(ar_cmd) - 1) ? 8'((beats_of(ar_cmd) - 1) % 16) : 8'd15;
      assert (araddr == exp_addr) else stop_run($sformatf(
        "Mismatch at %0t: cmd %0d burst %0d araddr %h, expected %h",
        $time, ar_cmd, ar_idx, araddr, exp_addr));
      assert (arlen == exp_len) else stop_run($sformatf(
        "Mismatch at %0t: cmd %0d burst %0d arlen %0d, expected %0d",
        $time, ar_cmd, ar_idx, arlen, exp_len));
      assert ((arsize == 3'd3) && (arburst == 2'b01)) else stop_run($sformatf(
        "Mismatch at %0t: arsize %0d arburst %0d, expected 3 and INCR",
        $time, arsize, arburst));
      // Single ID, normal access, bufferable and modifiable, unprivileged data
      assert ((arid == 2'd0) && (arlock == 1'b0) && (arcache == 4'b0011) &&
              (arprot == 3'b010)) else stop_run($sformatf(
        "Mismatch at %0t: arid %0d arlock %0d arcache %h arprot %h, expected 0 0 3 2",
        $time, arid, arlock, arcache, arprot));
      if (ar_idx == bursts_of(ar_cmd) - 1) begin
        ar_cmd++;
        ar_idx = 0;
      end else begin
        ar_idx++;
      end
    end
  endtask

  task automatic check_beat();
    logic [63:0] exp_data;
    logic        cmd_end;
    logic        exp_last;
    logic        exp_done;
    assert (s_cmd < N_CMD) else stop_run("Stream beat after the last command completed");
    if (s_cmd < N_CMD) begin
      exp_data = {32'd0, TBL_ADDR[s_cmd] + 32'(s_beat * 8)};
      cmd_end = (s_beat == beats_of(s_cmd) - 1);
      // Queue flag marks only the final burst of a command with ctl set
      exp_last = cmd_end && TBL_CTL[s_cmd];
      exp_done = cmd_end && TBL_CTL[s_cmd];
      assert (axis_out_tdata == exp_data) else stop_run($sformatf(
        "Mismatch at %0t: cmd %0d beat %0d tdata %h, expected %h",
        $time, s_cmd, s_beat, axis_out_tdata, exp_data));
      assert (axis_out_tkeep == 8'hff) else stop_run($sformatf(
        "Mismatch at %0t: tkeep %h, expected ff", $time, axis_out_tkeep));
      assert (axis_out_tlast == exp_last) else stop_run($sformatf(
        "Mismatch at %0t: cmd %0d beat %0d tlast %b, expected %b",
        $time, s_cmd, s_beat, axis_out_tlast, exp_last));
      assert (stat_done == exp_done) else stop_run($sformatf(
        "Mismatch at %0t: cmd %0d beat %0d stat_done %b, expected %b",
        $time, s_cmd, s_beat, stat_done, exp_done));
      if (cmd_end) begin
        s_cmd++;
        s_beat = 0;
      end else begin
        s_beat++;
      end
    end
  endtask

  // Sampled at the rising edge, inputs move only on the falling edge
  always @(posedge aclk) begin
    cycles++;
    assert (cycles < cycle_limit) else stop_run($sformatf(
      "Timeout after %0d cycles with %0d of %0d commands streamed", cycles, s_cmd, N_CMD));
    if (aresetn) begin
      // Stream and R are wired straight through
      assert ((rready == axis_out_tready) && (axis_out_tvalid == rvalid)) else stop_run(
        $sformatf("Mismatch at %0t: rready %b tvalid %b, expected %b and %b",
        $time, rready, axis_out_tvalid, axis_out_tready, rvalid));
      if (arvalid && arready) begin
        check_ar();
        outstanding++;
      end
      if (axis_out_tvalid && axis_out_tready) begin
        check_beat();
      end else begin
        assert (!stat_done) else stop_run($sformatf(
          "Mismatch at %0t: stat_done high without a stream beat", $time));
      end
      if (rvalid && rready && rlast) begin
        outstanding--;
      end
      assert (outstanding <= MAX_BURSTS) else stop_run($sformatf(
        "Mismatch at %0t: %0d bursts outstanding, limit %0d", $time, outstanding, MAX_BURSTS));
      // Acceptance while an earlier command is still streaming
      if (ctrl_valid && stat_ready) begin
        if (s_cmd < acc_count) begin
          overlap_seen = 1'b1;
        end
        acc_count++;
      end
    end
  end

  // Random stream back-pressure
  initial begin
    axis_out_tready = 1'b0;
    forever begin
      @(negedge aclk);
      axis_out_tready = ($urandom_range(3) != 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reset and command sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic taken;
    int   total;
    void'($urandom(SEED));
    aresetn = 1'b0;
    ctrl_valid = 1'b0;
    ctrl_addr = '0;
    ctrl_len = '0;
    ctrl_ctl = 1'b0;
    total = 0;
    for (int i = 0; i < N_CMD; i++) begin
      total += beats_of(i);
    end
    cycle_limit = 20 * total + 200;
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    @(posedge aclk);
    assert (stat_ready && !arvalid) else stop_run($sformatf(
      "Mismatch at %0t: after reset stat_ready %b arvalid %b", $time, stat_ready, arvalid));
    @(negedge aclk);
    for (int i = 0; i < N_CMD; i++) begin
      ctrl_valid = 1'b1;
      ctrl_addr = TBL_ADDR[i];
      ctrl_len = TBL_LEN[i];
      ctrl_ctl = TBL_CTL[i];
      taken = 1'b0;
      while (!taken) begin
        @(posedge aclk);
        taken = stat_ready;
      end
      @(negedge aclk);
    end
    ctrl_valid = 1'b0;
    wait (s_cmd == N_CMD);
    repeat (4) @(posedge aclk);
    assert (ar_cmd == N_CMD) else stop_run("Not every burst of the table was issued on AR");
    assert (outstanding == 0) else stop_run("Bursts left outstanding at the end of the run");
    assert (overlap_seen) else stop_run("No command was accepted while earlier data was returning");
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_axi_rd_slave.sv */
// AXI4 read slave model; in-order bursts on ID 0, rdata is the beat's byte address, OKAY only
`timescale 1ns/1ns
`default_nettype none

module tb_axi_rd_slave (
  input  wire                               aclk,
  input  wire                               aresetn,
  input  wire                               arvalid,
  output logic                              arready,
  input  wire  [axi_pkg::ADDR_BITS-1:0]     araddr,
  input  wire  [axi_pkg::LEN_W-1:0]         arlen,
  output logic                              rvalid,
  input  wire                               rready,
  output logic [axi_pkg::DATA_BITS-1:0]     rdata,
  output logic                              rlast,
  output logic [axi_pkg::ID_BITS-1:0]       rid,
  output logic [1:0]                        rresp
);

  // Accepted bursts waiting for their R beats
  logic [31:0] addr_q [$];
  logic [7:0]  len_q [$];

  // Handshakes seen at the last rising edge
  logic        ar_taken = 1'b0;
  logic        r_taken = 1'b0;
  logic [31:0] ar_addr_s = '0;
  logic [7:0]  ar_len_s = '0;

  // Burst now on R
  logic        active;
  logic [31:0] cur_addr;
  // Beats after the one on the bus
  logic [7:0]  beats_left;

  assign rid = '0;
  assign rresp = 2'b00;

  //////////////////////////////////////////////////////////////////////
  // Handshake capture
  //////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    ar_taken = aresetn && arvalid && arready;
    r_taken = aresetn && rvalid && rready;
    ar_addr_s = araddr;
    ar_len_s = arlen;
  end

  //////////////////////////////////////////////////////////////////////
  // Drive on the falling edge
  //////////////////////////////////////////////////////////////////////

  initial begin
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    rlast = 1'b0;
    active = 1'b0;
    cur_addr = '0;
    beats_left = '0;
    forever begin
      @(negedge aclk);
      if (!aresetn) begin
        arready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        active = 1'b0;
        addr_q.delete();
        len_q.delete();
      end else begin
        if (ar_taken) begin
          addr_q.push_back(ar_addr_s);
          len_q.push_back(ar_len_s);
        end
        // Beat taken, step to the next one or close the burst
        if (r_taken) begin
          rvalid = 1'b0;
          if (beats_left == 8'd0) begin
            active = 1'b0;
          end else begin
            cur_addr = cur_addr + 32'd8;
            beats_left = beats_left - 8'd1;
          end
        end
        if (!active && (addr_q.size() > 0)) begin
          cur_addr = addr_q.pop_front();
          beats_left = len_q.pop_front();
          active = 1'b1;
        end
        // Roughly one AR stall in four
        arready = ($urandom_range(3) != 0);
        // A pending beat holds until rready, gaps only between beats
        if (active && !rvalid && ($urandom_range(3) != 0)) begin
          rvalid = 1'b1;
          rdata = {32'd0, cur_addr};
          rlast = (beats_left == 8'd0);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dma_rd_top.sv */
// Aligned AXI4 read DMA; one command in decode, up to 4 bursts in flight, in-order slave assumed
`timescale 1ns/1ns
`default_nettype none

module dma_rd_top (
  input  wire                               aclk,
  input  wire                               aresetn,
  // Control and status
  input  wire                               ctrl_valid,
  output logic                              stat_ready,
  input  wire  [axi_pkg::ADDR_BITS-1:0]     ctrl_addr,
  input  wire  [dma_pkg::LEN_BITS-1:0]      ctrl_len,
  input  wire                               ctrl_ctl,
  output logic                              stat_done,
  // AXI4 read address
  output logic                              arvalid,
  input  wire                               arready,
  output logic [axi_pkg::ADDR_BITS-1:0]     araddr,
  output logic [axi_pkg::ID_BITS-1:0]       arid,
  output logic [axi_pkg::LEN_W-1:0]         arlen,
  output logic [2:0]                        arsize,
  output logic [1:0]                        arburst,
  output logic [0:0]                        arlock,
  output logic [3:0]                        arcache,
  output logic [2:0]                        arprot,
  // AXI4 read data
  input  wire                               rvalid,
  output logic                              rready,
  input  wire  [axi_pkg::DATA_BITS-1:0]     rdata,
  input  wire                               rlast,
  input  wire  [axi_pkg::ID_BITS-1:0]       rid,
  input  wire  [1:0]                        rresp,
  // AXI4-Stream out
  output logic                              axis_out_tvalid,
  input  wire                               axis_out_tready,
  output logic [axi_pkg::DATA_BITS-1:0]     axis_out_tdata,
  output logic [axi_pkg::DATA_BITS/8-1:0]   axis_out_tkeep,
  output logic                              axis_out_tlast
);

  //////////////////////////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////////////////////////

  logic                          start;
  logic [axi_pkg::ADDR_BITS-1:0] base_addr;
  logic [dma_pkg::XFER_W-1:0]    burst_count;
  logic [axi_pkg::LEN_W-1:0]     last_len;
  logic                          done_req;
  logic                          issue_done;
  // Burst queue, issuer side
  logic                          q_push;
  logic                          q_flag;
  logic                          q_full;

  dma_rd_cmd_decode i_decode (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .ctrl_valid  (ctrl_valid),
    .ctrl_addr   (ctrl_addr),
    .ctrl_len    (ctrl_len),
    .ctrl_ctl    (ctrl_ctl),
    .issue_done  (issue_done),
    .stat_ready  (stat_ready),
    .start       (start),
    .base_addr   (base_addr),
    .burst_count (burst_count),
    .last_len    (last_len),
    .done_req    (done_req)
  );

  dma_rd_ar_issue i_ar_issue (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .start       (start),
    .base_addr   (base_addr),
    .burst_count (burst_count),
    .last_len    (last_len),
    .done_req    (done_req),
    .q_full      (q_full),
    .arvalid     (arvalid),
    .arready     (arready),
    .araddr      (araddr),
    .arid        (arid),
    .arlen       (arlen),
    .arsize      (arsize),
    .arburst     (arburst),
    .arlock      (arlock),
    .arcache     (arcache),
    .arprot      (arprot),
    .q_push      (q_push),
    .q_flag      (q_flag),
    .issue_done  (issue_done)
  );

  dma_rd_r_stream i_r_stream (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .rvalid          (rvalid),
    .rready          (rready),
    .rdata           (rdata),
    .rlast           (rlast),
    .rid             (rid),
    .rresp           (rresp),
    .axis_out_tvalid (axis_out_tvalid),
    .axis_out_tready (axis_out_tready),
    .axis_out_tdata  (axis_out_tdata),
    .axis_out_tkeep  (axis_out_tkeep),
    .axis_out_tlast  (axis_out_tlast),
    .stat_done       (stat_done),
    .q_push          (q_push),
    .q_flag          (q_flag),
    .q_full          (q_full)
  );

endmodule

`default_nettype wire

/* dma_rd_r_stream.sv */
// R to stream; zero latency, no buffering, rresp ignored, bursts must return in order on ID 0
`timescale 1ns/1ns
`default_nettype none

module dma_rd_r_stream (
  input  wire                               aclk,
  input  wire                               aresetn,
  input  wire                               rvalid,
  output logic                              rready,
  input  wire  [axi_pkg::DATA_BITS-1:0]     rdata,
  input  wire                               rlast,
  input  wire  [axi_pkg::ID_BITS-1:0]       rid,
  input  wire  [1:0]                        rresp,
  output logic                              axis_out_tvalid,
  input  wire                               axis_out_tready,
  output logic [axi_pkg::DATA_BITS-1:0]     axis_out_tdata,
  output logic [axi_pkg::DATA_BITS/8-1:0]   axis_out_tkeep,
  output logic                              axis_out_tlast,
  output logic                              stat_done,
  input  wire                               q_push,
  input  wire                               q_flag,
  output logic                              q_full
);

  logic rxfer;
  logic head_flag;

  // Stream stalls R directly
  assign rready = axis_out_tready;
  assign rxfer = rvalid && axis_out_tready;

  assign axis_out_tvalid = rvalid;
  assign axis_out_tdata = rdata;
  assign axis_out_tkeep = '1;

  // Head flag belongs to the burst now on R
  assign axis_out_tlast = rlast && head_flag;
  assign stat_done = rxfer && rlast && head_flag;

  // Pop when a burst's last beat leaves
  dma_rd_burst_fifo i_burst_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (q_push),
    .push_flag (q_flag),
    .pop       (rxfer && rlast),
    .head_flag (head_flag),
    .full      (q_full)
  );

  // Single ID, response field must still be driven
  a_r_id: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid |-> (rid == '0) && !$isunknown(rresp));

endmodule

`default_nettype wire

/* dma_rd_burst_fifo.sv */
// Burst flag queue, MAX_OUTSTANDING deep; no push when full, no pop when empty
`timescale 1ns/1ns
`default_nettype none

module dma_rd_burst_fifo (
  input  wire  aclk,
  input  wire  aresetn,
  input  wire  push,
  input  wire  push_flag,
  input  wire  pop,
  output logic head_flag,
  output logic full
);

  // New entries enter at bit 0, the oldest sits at count-1
  logic [dma_pkg::MAX_OUTSTANDING-1:0] sr;
  logic [dma_pkg::CNT_W-1:0]           count;

  //////////////////////////////////////////////////////////////////////
  // Storage and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (push) begin
      sr <= {sr[dma_pkg::MAX_OUTSTANDING-2:0], push_flag};
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        // Both or neither, depth unchanged
        default: count <= count;
      endcase
    end
  end

  assign full = (count == dma_pkg::CNT_W'(dma_pkg::MAX_OUTSTANDING));

  // Head select, low when empty
  always_comb begin
    head_flag = 1'b0;
    for (int i = 0; i < dma_pkg::MAX_OUTSTANDING; i++) begin
      if (count == dma_pkg::CNT_W'(i + 1)) begin
        head_flag = sr[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Issuer must hold off on a full queue
  a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
    push |-> !full);

  // An R burst came back with no AR behind it
  a_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn)
    pop |-> (count != '0));

endmodule

`default_nettype wire

/* dma_rd_ar_issue.sv */
// AR issuer; one gap cycle after each handshake, stalls while the burst queue is full
`timescale 1ns/1ns
`default_nettype none

module dma_rd_ar_issue (
  input  wire                           aclk,
  input  wire                           aresetn,
  input  wire                           start,
  input  wire [axi_pkg::ADDR_BITS-1:0]  base_addr,
  input  wire [dma_pkg::XFER_W-1:0]     burst_count,
  input  wire [axi_pkg::LEN_W-1:0]      last_len,
  input  wire                           done_req,
  input  wire                           q_full,
  output logic                          arvalid,
  input  wire                           arready,
  output logic [axi_pkg::ADDR_BITS-1:0] araddr,
  output logic [axi_pkg::ID_BITS-1:0]   arid,
  output logic [axi_pkg::LEN_W-1:0]     arlen,
  output logic [2:0]                    arsize,
  output logic [1:0]                    arburst,
  output logic [0:0]                    arlock,
  output logic [3:0]                    arcache,
  output logic [2:0]                    arprot,
  output logic                          q_push,
  output logic                          q_flag,
  output logic                          issue_done
);

  dma_pkg::ar_state_e state;

  logic [axi_pkg::ADDR_BITS-1:0] addr_r;
  // Bursts left after the current one
  logic [dma_pkg::XFER_W-1:0]    to_go;
  logic [axi_pkg::LEN_W-1:0]     last_len_r;
  logic                          done_req_r;
  logic                          arxfer;
  logic                          final_burst;
  // End offset of the burst inside its 4 KB page
  logic [12:0]                   burst_end;

  assign arxfer = arvalid && arready;
  assign final_burst = (to_go == '0);

  //////////////////////////////////////////////////////////////////////
  // AR channel fields
  //////////////////////////////////////////////////////////////////////

  assign araddr = addr_r;
  assign arid = '0;
  assign arlen = final_burst ? last_len_r : axi_pkg::LEN_W'(dma_pkg::BURST_LEN - 1);
  assign arsize = axi_pkg::ARSIZE_FULL;
  assign arburst = axi_pkg::ARBURST_INCR;
  assign arlock = 1'b0;
  assign arcache = axi_pkg::ARCACHE_DEF;
  assign arprot = axi_pkg::ARPROT_DEF;

  // One queue entry per burst, flagged on the last one if done was asked
  assign q_push = arxfer;
  assign q_flag = done_req_r && final_burst;
  assign issue_done = arxfer && final_burst;

  //////////////////////////////////////////////////////////////////////
  // Issue FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= dma_pkg::ar_idle;
      arvalid <= 1'b0;
    end else begin
      case (state)
        dma_pkg::ar_idle: begin
          // Queue has nothing of ours yet, so q_full is current here
          if (start) begin
            arvalid <= !q_full;
            state <= q_full ? dma_pkg::ar_wait_room : dma_pkg::ar_issue;
          end
        end
        dma_pkg::ar_issue: begin
          if (arready) begin
            arvalid <= 1'b0;
            state <= final_burst ? dma_pkg::ar_idle : dma_pkg::ar_wait_room;
          end
        end
        dma_pkg::ar_wait_room: begin
          // q_full already counts the burst just pushed
          if (!q_full) begin
            arvalid <= 1'b1;
            state <= dma_pkg::ar_issue;
          end
        end
        default: state <= dma_pkg::ar_idle;
      endcase
    end
  end

  // Address and burst countdown
  always_ff @(posedge aclk) begin
    if (start) begin
      addr_r <= base_addr;
      to_go <= burst_count;
      last_len_r <= last_len;
      done_req_r <= done_req;
    end else if (arxfer) begin
      addr_r <= addr_r + dma_pkg::BURST_BYTES;
      to_go <= to_go - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  assign burst_end = {1'b0, araddr[11:0]} + (({5'd0, arlen} + 13'd1) << arsize);

  // AR must hold until the slave takes it
  a_ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (arvalid && !arready) |=> (arvalid && $stable(araddr) && $stable(arlen)));

  // Aligned start keeps every burst inside one page
  a_ar_4k: assert property (@(posedge aclk) disable iff (!aresetn)
    arvalid |-> (burst_end <= 13'h1000));

endmodule

`default_nettype wire

/* dma_rd_cmd_decode.sv */
// Command decode; takes one command at a time, address must be 128-byte aligned, len 8-byte units
`timescale 1ns/1ns
`default_nettype none

module dma_rd_cmd_decode (
  input  wire                           aclk,
  input  wire                           aresetn,
  input  wire                           ctrl_valid,
  input  wire [axi_pkg::ADDR_BITS-1:0]  ctrl_addr,
  input  wire [dma_pkg::LEN_BITS-1:0]   ctrl_len,
  input  wire                           ctrl_ctl,
  input  wire                           issue_done,
  output logic                          stat_ready,
  output logic                          start,
  output logic [axi_pkg::ADDR_BITS-1:0] base_addr,
  output logic [dma_pkg::XFER_W-1:0]    burst_count,
  output logic [axi_pkg::LEN_W-1:0]     last_len,
  output logic                          done_req
);

  dma_pkg::dec_state_e state;

  logic                           accept;
  logic [dma_pkg::XFER_W-1:0]     num_full;
  logic [dma_pkg::LOG_BURST-1:0]  part_beats;
  logic                           has_partial;
  logic [dma_pkg::LOG_BURST-1:0]  last_beats;

  //////////////////////////////////////////////////////////////////////
  // Length split
  //////////////////////////////////////////////////////////////////////

  assign accept = ctrl_valid && stat_ready;
  assign stat_ready = (state == dma_pkg::dec_idle);

  // Whole bursts sit above bit 7 of the length
  assign num_full = ctrl_len[dma_pkg::LEN_BITS-1:dma_pkg::LOG_DATA+dma_pkg::LOG_BURST];
  // Leftover beats, zero when the length is a burst multiple
  assign part_beats = ctrl_len[dma_pkg::LOG_DATA +: dma_pkg::LOG_BURST];
  assign has_partial = |part_beats;
  // Wraps to 15 with no leftover, which is a full final burst
  assign last_beats = part_beats - 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= dma_pkg::dec_idle;
      start <= 1'b0;
    end else begin
      // Issuer loads one cycle after acceptance
      start <= accept;
      case (state)
        dma_pkg::dec_idle: begin
          if (accept) begin
            state <= dma_pkg::dec_busy;
          end
        end
        dma_pkg::dec_busy: begin
          // Last AR is out, data may still be returning
          if (issue_done) begin
            state <= dma_pkg::dec_idle;
          end
        end
        default: state <= dma_pkg::dec_idle;
      endcase
    end
  end

  // Command fields for the issuer
  always_ff @(posedge aclk) begin
    if (accept) begin
      base_addr <= ctrl_addr;
      // Count holds bursts minus one
      burst_count <= has_partial ? num_full : num_full - 1'b1;
      last_len <= axi_pkg::LEN_W'(last_beats);
      done_req <= ctrl_ctl;
    end
  end

  // Accepted commands meet the alignment the engine relies on
  a_cmd_aligned: assert property (@(posedge aclk) disable iff (!aresetn)
    accept |-> (ctrl_len != '0) &&
               (ctrl_len[dma_pkg::LOG_DATA-1:0] == '0) &&
               (ctrl_addr[dma_pkg::LOG_DATA+dma_pkg::LOG_BURST-1:0] == '0));

  // Issuer only finishes a command this stage handed over
  a_done_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    issue_done |-> (state == dma_pkg::dec_busy));

endmodule

`default_nettype wire

/* dma_pkg.sv */
// DMA sizing and FSM encodings; lengths up to 1 MB, bursts of 16 beats of 8 bytes
`default_nettype none

package dma_pkg;

  //////////////////////////////////////////////////////////////////////
  // Command and burst sizing
  //////////////////////////////////////////////////////////////////////

  // Command length in bytes
  localparam int LEN_BITS = 20;
  // Beats per full burst
  localparam int BURST_LEN = 16;
  localparam int DATA_BYTES = 8;
  localparam int LOG_DATA = 3;
  localparam int LOG_BURST = 4;
  // Bursts allowed in flight between AR and the last R beat
  localparam int MAX_OUTSTANDING = 4;
  // Burst counter, length bits above one full burst
  localparam int XFER_W = LEN_BITS - 7;
  // Address step from one burst to the next
  localparam int BURST_BYTES = BURST_LEN * DATA_BYTES;
  // Holds 0 to MAX_OUTSTANDING
  localparam int CNT_W = 3;

  //////////////////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////////////////

  // Command decode
  typedef enum logic [0:0] {
    dec_idle,
    dec_busy
  } dec_state_e;

  // AR issuer
  typedef enum logic [1:0] {
    ar_idle,
    ar_issue,
    ar_wait_room
  } ar_state_e;

endpackage

`default_nettype wire

/* axi_pkg.sv */
// AXI4 read widths and fixed AR attributes; INCR bursts only, one ID, full-width beats
`default_nettype none

package axi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Byte address
  localparam int ADDR_BITS = 32;
  // Read data bus, 8 bytes
  localparam int DATA_BITS = 64;
  localparam int ID_BITS = 2;
  // arlen field of AXI4
  localparam int LEN_W = 8;

  //////////////////////////////////////////////////////////////////////
  // Fixed AR attributes
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] ARBURST_INCR = 2'b01;
  // Bufferable and modifiable
  localparam logic [3:0] ARCACHE_DEF = 4'b0011;
  // Unprivileged, non-secure, data access
  localparam logic [2:0] ARPROT_DEF = 3'b010;
  // log2 of bytes per beat, always the full bus
  localparam logic [2:0] ARSIZE_FULL = 3'd3;

endpackage

`default_nettype wire
